/* verilog/periph_pkg.sv */
`default_nettype none

package periph_pkg;

  // pad bank sizes
  localparam int SAM_PINS = 23;   // header pads
  localparam int WM_PINS  = 21;   // radio module pads

  // host register port
  localparam int REG_W = 32;

  // power-on reset stretch, top bit set means done (32 cycles)
  localparam int RST_CNT_W = 6;

  // one bit per pad of a bank
  typedef logic [SAM_PINS-1:0] sam_vec_t;
  typedef logic [WM_PINS-1:0]  wm_vec_t;

endpackage

`default_nettype wire

/* verilog/pinmux_pkg.sv */
`default_nettype none

package pinmux_pkg;

  // per-pin function select, two bits in the select registers
  typedef enum logic [1:0] {
    FUNC_GPIO = 2'd0,   // out/dir registers
    FUNC_ALT1 = 2'd1,   // always driven
    FUNC_ALT2 = 2'd2,   // own output enable
    FUNC_ALT3 = 2'd3    // own output enable
  } pin_func_e;

  typedef enum logic [3:0] {
    REG_SAM_OUT    = 4'd0,
    REG_SAM_DIR    = 4'd1,
    REG_SAM_SEL_LO = 4'd2,
    REG_SAM_SEL_HI = 4'd3,
    REG_WM_OUT     = 4'd4,
    REG_WM_DIR     = 4'd5,
    REG_WM_SEL_LO  = 4'd6,
    REG_WM_SEL_HI  = 4'd7,
    REG_SAM_IN     = 4'd8,
    REG_WM_IN      = 4'd9,
    REG_STATUS     = 4'd10
  } reg_addr_e;

  localparam int SEL_LO_PINS = 16;  // pins held in a SEL_LO register

  // radio pin in ALT1 feeds header pin in GPIO
  localparam int BYP_MISO_SAM = 18;
  localparam int BYP_MISO_WM  = 20;
  localparam int BYP_TX_SAM   = 21;
  localparam int BYP_TX_WM    = 15;
  localparam int BYP_ACK_SAM  = 12;
  localparam int BYP_ACK_WM   = 5;

  // header pads routed onto radio ALT1
  localparam int BYP_RX_WM    = 15;
  localparam int BYP_RX_SAM   = 22;
  localparam int BYP_RST_WM   = 0;
  localparam int BYP_RST_SAM  = 15;
  localparam int BYP_GPIO0_WM  = 10;
  localparam int BYP_GPIO0_SAM = 14;

endpackage

`default_nettype wire

/* verilog/pio_bank_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface pio_bank_if #(
  parameter int NUM_PINS = 8
) ();
  import pinmux_pkg::*;

  logic [NUM_PINS-1:0] out;       // gpio output value
  logic [NUM_PINS-1:0] dir;       // 1 = output
  pin_func_e           sel [NUM_PINS];
  logic [NUM_PINS-1:0] in_sync;   // pads after the synchronizer

  modport regs (output out, output dir, output sel, input in_sync);
  modport sync (output in_sync, input sel);
  modport mux  (input out, input dir, input sel);

endinterface

`default_nettype wire

/* verilog/reset_stretch.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_stretch
(
  input  wire  wMEM_CLK,
  input  wire  rst_n_i,
  output logic sys_rst_n_o,
  output logic sys_ready_o
);
  import periph_pkg::*;

  logic [RST_CNT_W-1:0] cnt_q;

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else if (!cnt_q[RST_CNT_W-1])
      cnt_q <= cnt_q + 1'b1;   // stops once the top bit sets
  end

  assign sys_rst_n_o = cnt_q[RST_CNT_W-1];
  assign sys_ready_o = cnt_q[RST_CNT_W-1];

  // no drop out of ready while the board reset stays high
  a_ready_sticky: assert property (@(posedge wMEM_CLK) disable iff (!rst_n_i)
    sys_ready_o |=> sys_ready_o);

endmodule

`default_nettype wire

/* verilog/pio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module pio_regs
(
  input  wire                          wMEM_CLK,
  input  wire                          rst_n_i,
  input  wire                          reg_we_i,
  input  wire                          reg_re_i,
  input  wire pinmux_pkg::reg_addr_e   reg_addr_i,
  input  wire [periph_pkg::REG_W-1:0]  reg_wdata_i,
  output logic [periph_pkg::REG_W-1:0] reg_rdata_o,
  output logic                         reg_rvalid_o,
  pio_bank_if.regs                     sam_bank,
  pio_bank_if.regs                     wm_bank
);
  import periph_pkg::*;
  import pinmux_pkg::*;

  sam_vec_t              sam_out_q;
  sam_vec_t              sam_dir_q;
  logic [2*SAM_PINS-1:0] sam_sel_q;   // two bits per pin
  wm_vec_t               wm_out_q;
  wm_vec_t               wm_dir_q;
  logic [2*WM_PINS-1:0]  wm_sel_q;
  logic [REG_W-1:0]      rdata_d;
  logic [REG_W-1:0]      rdata_q;
  logic                  rvalid_q;

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
    begin
      sam_out_q <= '0;
      sam_dir_q <= '0;
      sam_sel_q <= '0;   // all pins GPIO
      wm_out_q  <= '0;
      wm_dir_q  <= '0;
      wm_sel_q  <= '0;
    end
    else if (reg_we_i)
    begin
      case (reg_addr_i)
        REG_SAM_OUT:    sam_out_q <= reg_wdata_i[SAM_PINS-1:0];
        REG_SAM_DIR:    sam_dir_q <= reg_wdata_i[SAM_PINS-1:0];
        REG_SAM_SEL_LO: sam_sel_q[2*SEL_LO_PINS-1:0] <= reg_wdata_i[2*SEL_LO_PINS-1:0];
        REG_SAM_SEL_HI:
          sam_sel_q[2*SAM_PINS-1:2*SEL_LO_PINS] <=
            reg_wdata_i[2*(SAM_PINS-SEL_LO_PINS)-1:0];
        REG_WM_OUT:     wm_out_q <= reg_wdata_i[WM_PINS-1:0];
        REG_WM_DIR:     wm_dir_q <= reg_wdata_i[WM_PINS-1:0];
        REG_WM_SEL_LO:  wm_sel_q[2*SEL_LO_PINS-1:0] <= reg_wdata_i[2*SEL_LO_PINS-1:0];
        REG_WM_SEL_HI:
          wm_sel_q[2*WM_PINS-1:2*SEL_LO_PINS] <=
            reg_wdata_i[2*(WM_PINS-SEL_LO_PINS)-1:0];
        default: ;   // input and status registers are read only
      endcase
    end
  end

  assign sam_bank.out = sam_out_q;
  assign sam_bank.dir = sam_dir_q;
  assign wm_bank.out  = wm_out_q;
  assign wm_bank.dir  = wm_dir_q;

  always_comb
  begin
    for (int i = 0; i < SAM_PINS; i++)
      sam_bank.sel[i] = pin_func_e'(sam_sel_q[2*i +: 2]);
    for (int i = 0; i < WM_PINS; i++)
      wm_bank.sel[i] = pin_func_e'(wm_sel_q[2*i +: 2]);
  end

  // read mux, unused upper bits come back as 0
  always_comb
  begin
    case (reg_addr_i)
      REG_SAM_OUT:    rdata_d = REG_W'(sam_out_q);
      REG_SAM_DIR:    rdata_d = REG_W'(sam_dir_q);
      REG_SAM_SEL_LO: rdata_d = REG_W'(sam_sel_q[2*SEL_LO_PINS-1:0]);
      REG_SAM_SEL_HI: rdata_d = REG_W'(sam_sel_q[2*SAM_PINS-1:2*SEL_LO_PINS]);
      REG_WM_OUT:     rdata_d = REG_W'(wm_out_q);
      REG_WM_DIR:     rdata_d = REG_W'(wm_dir_q);
      REG_WM_SEL_LO:  rdata_d = REG_W'(wm_sel_q[2*SEL_LO_PINS-1:0]);
      REG_WM_SEL_HI:  rdata_d = REG_W'(wm_sel_q[2*WM_PINS-1:2*SEL_LO_PINS]);
      REG_SAM_IN:     rdata_d = REG_W'(sam_bank.in_sync);
      REG_WM_IN:      rdata_d = REG_W'(wm_bank.in_sync);
      REG_STATUS:     rdata_d = REG_W'(rst_n_i);   // stretched reset high = ready
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= reg_re_i;   // one cycle read latency
  end

  always_ff @(posedge wMEM_CLK)
  begin
    if (reg_re_i)
      rdata_q <= rdata_d;
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

  // back to back valids need back to back reads
  a_rvalid_pairs: assert property (@(posedge wMEM_CLK) disable iff (!rst_n_i)
    reg_rvalid_o && $past(reg_rvalid_o) |-> $past(reg_re_i) && $past(reg_re_i, 2));

endmodule

`default_nettype wire

/* verilog/pad_sync_route.sv */
`timescale 1ns/10ps
`default_nettype none

module pad_sync_route
(
  input  wire                        wMEM_CLK,
  input  wire                        rst_n_i,
  input  wire periph_pkg::sam_vec_t  sam_pad_i,
  input  wire periph_pkg::wm_vec_t   wm_pad_i,
  pio_bank_if.sync                   sam_bank,
  pio_bank_if.sync                   wm_bank,
  output periph_pkg::sam_vec_t       sam_byp_en_o,
  output periph_pkg::sam_vec_t       sam_byp_val_o,
  output periph_pkg::wm_vec_t        wm_alt1_o
);
  import periph_pkg::*;
  import pinmux_pkg::*;

  sam_vec_t sam_meta_q;
  sam_vec_t sam_sync_q;
  wm_vec_t  wm_meta_q;
  wm_vec_t  wm_sync_q;

  always_ff @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
    begin
      sam_meta_q <= '0;
      sam_sync_q <= '0;
      wm_meta_q  <= '0;
      wm_sync_q  <= '0;
    end
    else
    begin
      sam_meta_q <= sam_pad_i;   // first stage may go metastable
      sam_sync_q <= sam_meta_q;
      wm_meta_q  <= wm_pad_i;
      wm_sync_q  <= wm_meta_q;
    end
  end

  assign sam_bank.in_sync = sam_sync_q;
  assign wm_bank.in_sync  = wm_sync_q;

  // radio pin in ALT1 passes straight through to its header pin
  always_comb
  begin
    sam_byp_en_o  = '0;
    sam_byp_val_o = '0;
    sam_byp_en_o[BYP_MISO_SAM]  = (wm_bank.sel[BYP_MISO_WM] == FUNC_ALT1);
    sam_byp_val_o[BYP_MISO_SAM] = wm_sync_q[BYP_MISO_WM];
    sam_byp_en_o[BYP_TX_SAM]    = (wm_bank.sel[BYP_TX_WM] == FUNC_ALT1);
    sam_byp_val_o[BYP_TX_SAM]   = wm_sync_q[BYP_TX_WM];
    sam_byp_en_o[BYP_ACK_SAM]   = (wm_bank.sel[BYP_ACK_WM] == FUNC_ALT1);
    sam_byp_val_o[BYP_ACK_SAM]  = wm_sync_q[BYP_ACK_WM];
  end

  // header pads onto radio ALT1 (rx, reset, gpio0)
  always_comb
  begin
    wm_alt1_o = '0;
    wm_alt1_o[BYP_RX_WM]    = sam_sync_q[BYP_RX_SAM];
    wm_alt1_o[BYP_RST_WM]   = sam_sync_q[BYP_RST_SAM];
    wm_alt1_o[BYP_GPIO0_WM] = sam_sync_q[BYP_GPIO0_SAM];
  end

endmodule

`default_nettype wire

/* verilog/pin_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module pin_mux #(
  parameter int NUM_PINS = 8
)
(
  pio_bank_if.mux             bank,
  input  wire [NUM_PINS-1:0]  byp_en_i,
  input  wire [NUM_PINS-1:0]  byp_val_i,
  input  wire [NUM_PINS-1:0]  alt1_i,
  input  wire [NUM_PINS-1:0]  alt2_i,
  input  wire [NUM_PINS-1:0]  alt2_oe_i,
  input  wire [NUM_PINS-1:0]  alt3_i,
  input  wire [NUM_PINS-1:0]  alt3_oe_i,
  output logic [NUM_PINS-1:0] pad_o,
  output logic [NUM_PINS-1:0] pad_oe_o
);
  import pinmux_pkg::*;

  always_comb
  begin
    pad_o    = '0;
    pad_oe_o = '0;
    for (int i = 0; i < NUM_PINS; i++)
    begin
      case (bank.sel[i])
        FUNC_GPIO:
        begin
          if (byp_en_i[i])
          begin
            pad_o[i]    = byp_val_i[i];   // bypass wins over the gpio regs
            pad_oe_o[i] = 1'b1;
          end
          else
          begin
            pad_o[i]    = bank.out[i];
            pad_oe_o[i] = bank.dir[i];
          end
        end
        FUNC_ALT1:
        begin
          pad_o[i]    = alt1_i[i];
          pad_oe_o[i] = 1'b1;
        end
        FUNC_ALT2:
        begin
          pad_o[i]    = alt2_i[i];
          pad_oe_o[i] = alt2_oe_i[i];
        end
        default:
        begin
          pad_o[i]    = alt3_i[i];   // FUNC_ALT3
          pad_oe_o[i] = alt3_oe_i[i];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/flash_pin_share.sv */
`timescale 1ns/10ps
`default_nettype none

module flash_pin_share
(
  input  wire        spi_sck_i,
  input  wire        spi_cs_n_i,
  input  wire        spi_mosi_i,
  input  wire        qspi_clk_i,
  input  wire        qspi_ncs_i,
  input  wire        qspi_oe_n_i,
  input  wire [3:0]  qspi_dout_i,
  input  wire [3:0]  qspi_doe_i,
  input  wire [3:0]  flash_io_i,
  output logic       spi_miso_o,
  output logic [3:0] qspi_din_o,
  output logic       flash_sck_o,
  output logic       flash_cs_n_o,
  output logic [3:0] flash_io_o,
  output logic [3:0] flash_io_oe_o
);

  logic qspi_act;
  logic spi_act;

  assign qspi_act = !qspi_ncs_i && !qspi_oe_n_i;   // quad master owns the pins
  assign spi_act  = !spi_cs_n_i;

  assign flash_cs_n_o = qspi_ncs_i & spi_cs_n_i;
  assign flash_sck_o  = qspi_act ? qspi_clk_i : (spi_act & spi_sck_i);

  always_comb
  begin
    flash_io_o    = 4'b0000;
    flash_io_oe_o = 4'b0000;
    if (qspi_act)
    begin
      flash_io_o    = qspi_dout_i;
      flash_io_oe_o = qspi_doe_i;
    end
    else if (spi_act)
    begin
      flash_io_o    = {2'b11, 1'b0, spi_mosi_i};   // hold and wp high, io1 is miso
      flash_io_oe_o = 4'b1101;
    end
  end

  assign qspi_din_o = flash_io_i;
  assign spi_miso_o = flash_io_i[1];

  // the two masters never select the flash at the same time
  a_one_cs: assert property (@(posedge qspi_clk_i) !qspi_ncs_i |-> spi_cs_n_i);

endmodule

`default_nettype wire

/* verilog/periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top
(
  input  wire                          wMEM_CLK,
  input  wire                          rst_n_i,
  input  wire                          reg_we_i,
  input  wire                          reg_re_i,
  input  wire pinmux_pkg::reg_addr_e   reg_addr_i,
  input  wire [periph_pkg::REG_W-1:0]  reg_wdata_i,
  output logic [periph_pkg::REG_W-1:0] reg_rdata_o,
  output logic                         reg_rvalid_o,
  output logic                         sys_ready_o,
  input  wire periph_pkg::sam_vec_t    sam_pad_i,
  input  wire periph_pkg::sam_vec_t    sam_alt1_i,
  input  wire periph_pkg::sam_vec_t    sam_alt2_i,
  input  wire periph_pkg::sam_vec_t    sam_alt2_oe_i,
  input  wire periph_pkg::sam_vec_t    sam_alt3_i,
  input  wire periph_pkg::sam_vec_t    sam_alt3_oe_i,
  output periph_pkg::sam_vec_t         sam_pad_o,
  output periph_pkg::sam_vec_t         sam_pad_oe_o,
  input  wire periph_pkg::wm_vec_t     wm_pad_i,
  input  wire periph_pkg::wm_vec_t     wm_alt2_i,
  input  wire periph_pkg::wm_vec_t     wm_alt3_i,
  output periph_pkg::wm_vec_t          wm_pad_o,
  output periph_pkg::wm_vec_t          wm_pad_oe_o,
  input  wire                          spi_sck_i,
  input  wire                          spi_cs_n_i,
  input  wire                          spi_mosi_i,
  output logic                         spi_miso_o,
  input  wire                          qspi_clk_i,
  input  wire                          qspi_ncs_i,
  input  wire                          qspi_oe_n_i,
  input  wire [3:0]                    qspi_dout_i,
  input  wire [3:0]                    qspi_doe_i,
  output logic [3:0]                   qspi_din_o,
  input  wire [3:0]                    flash_io_i,
  output logic                         flash_sck_o,
  output logic                         flash_cs_n_o,
  output logic [3:0]                   flash_io_o,
  output logic [3:0]                   flash_io_oe_o
);
  import periph_pkg::*;

  logic     sys_rst_n;     // stretched reset
  sam_vec_t sam_byp_en;
  sam_vec_t sam_byp_val;
  wm_vec_t  wm_alt1;       // bypass routes from the header bank

  pio_bank_if #(.NUM_PINS(SAM_PINS)) sam_bank ();
  pio_bank_if #(.NUM_PINS(WM_PINS))  wm_bank ();

  reset_stretch reset_stretch_i (
    .wMEM_CLK    (wMEM_CLK),
    .rst_n_i     (rst_n_i),
    .sys_rst_n_o (sys_rst_n),
    .sys_ready_o (sys_ready_o)
  );

  pio_regs pio_regs_i (
    .wMEM_CLK     (wMEM_CLK),
    .rst_n_i      (sys_rst_n),
    .reg_we_i     (reg_we_i),
    .reg_re_i     (reg_re_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .sam_bank     (sam_bank),
    .wm_bank      (wm_bank)
  );

  pad_sync_route pad_sync_route_i (
    .wMEM_CLK      (wMEM_CLK),
    .rst_n_i       (sys_rst_n),
    .sam_pad_i     (sam_pad_i),
    .wm_pad_i      (wm_pad_i),
    .sam_bank      (sam_bank),
    .wm_bank       (wm_bank),
    .sam_byp_en_o  (sam_byp_en),
    .sam_byp_val_o (sam_byp_val),
    .wm_alt1_o     (wm_alt1)
  );

  pin_mux #(.NUM_PINS(SAM_PINS)) sam_mux_i (
    .bank      (sam_bank),
    .byp_en_i  (sam_byp_en),
    .byp_val_i (sam_byp_val),
    .alt1_i    (sam_alt1_i),
    .alt2_i    (sam_alt2_i),
    .alt2_oe_i (sam_alt2_oe_i),
    .alt3_i    (sam_alt3_i),
    .alt3_oe_i (sam_alt3_oe_i),
    .pad_o     (sam_pad_o),
    .pad_oe_o  (sam_pad_oe_o)
  );

  // radio bank has no bypass and push-pull ALT functions
  pin_mux #(.NUM_PINS(WM_PINS)) wm_mux_i (
    .bank      (wm_bank),
    .byp_en_i  ({WM_PINS{1'b0}}),
    .byp_val_i (wm_alt1),
    .alt1_i    (wm_alt1),
    .alt2_i    (wm_alt2_i),
    .alt2_oe_i ({WM_PINS{1'b1}}),
    .alt3_i    (wm_alt3_i),
    .alt3_oe_i ({WM_PINS{1'b1}}),
    .pad_o     (wm_pad_o),
    .pad_oe_o  (wm_pad_oe_o)
  );

  flash_pin_share flash_pin_share_i (
    .spi_sck_i     (spi_sck_i),
    .spi_cs_n_i    (spi_cs_n_i),
    .spi_mosi_i    (spi_mosi_i),
    .qspi_clk_i    (qspi_clk_i),
    .qspi_ncs_i    (qspi_ncs_i),
    .qspi_oe_n_i   (qspi_oe_n_i),
    .qspi_dout_i   (qspi_dout_i),
    .qspi_doe_i    (qspi_doe_i),
    .flash_io_i    (flash_io_i),
    .spi_miso_o    (spi_miso_o),
    .qspi_din_o    (qspi_din_o),
    .flash_sck_o   (flash_sck_o),
    .flash_cs_n_o  (flash_cs_n_o),
    .flash_io_o    (flash_io_o),
    .flash_io_oe_o (flash_io_oe_o)
  );

endmodule

`default_nettype wire

/* bench/tb_periph.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_periph;
  import periph_pkg::*;
  import pinmux_pkg::*;

  localparam int READY_CYCLES   = 32;    // power-on stretch length
  localparam int TIMEOUT_CYCLES = 600;   // reset phase plus about 400 test cycles
  localparam int SAM_HI_BITS    = 2*(SAM_PINS-SEL_LO_PINS);
  localparam int WM_HI_BITS     = 2*(WM_PINS-SEL_LO_PINS);

  logic             wMEM_CLK, rst_n_i;
  logic             reg_we_i, reg_re_i, reg_rvalid_o, sys_ready_o;
  reg_addr_e        reg_addr_i;
  logic [REG_W-1:0] reg_wdata_i, reg_rdata_o;
  sam_vec_t         sam_pad_i, sam_alt1_i, sam_alt2_i, sam_alt2_oe_i, sam_alt3_i, sam_alt3_oe_i;
  sam_vec_t         sam_pad_o, sam_pad_oe_o;
  wm_vec_t          wm_pad_i, wm_alt2_i, wm_alt3_i, wm_pad_o, wm_pad_oe_o;
  logic             spi_sck_i, spi_cs_n_i, spi_mosi_i, spi_miso_o;
  logic             qspi_clk_i, qspi_ncs_i, qspi_oe_n_i;
  logic [3:0]       qspi_dout_i, qspi_doe_i, qspi_din_o, flash_io_i;
  logic             flash_sck_o, flash_cs_n_o;
  logic [3:0]       flash_io_o, flash_io_oe_o;

  int                    seed = 54;
  int                    cycles = 0;
  int                    edges_since_rst = 0;
  logic                  tb_ready;               // expected stretched reset state
  logic [REG_W-1:0]      exp_rdata;
  logic [REG_W-1:0]      regs_m [16];            // expected register contents
  logic [2*SAM_PINS-1:0] sam_sel_m;
  logic [2*WM_PINS-1:0]  wm_sel_m;
  sam_vec_t              sam_d1, sam_d2, byp_en_m, byp_val_m, exp_sam_pad, exp_sam_oe;
  wm_vec_t               wm_d1, wm_d2, wm_alt1_m, exp_wm_pad, exp_wm_oe;

  periph_top periph_top_i (.*);

  initial
  begin
    wMEM_CLK = 1'b0;
    forever #2 wMEM_CLK = ~wMEM_CLK;
  end

  always @(posedge wMEM_CLK)
  begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

  task automatic report_error(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic logic [REG_W-1:0] reg_mask(input reg_addr_e addr);
    logic [REG_W-1:0] ones;
    ones = '1;
    case (addr)
      REG_SAM_OUT, REG_SAM_DIR:      reg_mask = ones >> (REG_W - SAM_PINS);
      REG_WM_OUT, REG_WM_DIR:        reg_mask = ones >> (REG_W - WM_PINS);
      REG_SAM_SEL_LO, REG_WM_SEL_LO: reg_mask = ones;   // 16 pins fill the word
      REG_SAM_SEL_HI:                reg_mask = ones >> (REG_W - SAM_HI_BITS);
      REG_WM_SEL_HI:                 reg_mask = ones >> (REG_W - WM_HI_BITS);
      default:                       reg_mask = '0;     // read only
    endcase
  endfunction

  // returns {oe, value} of one pad
  function automatic logic [1:0] pin_expect(input logic [1:0] sel, input logic out,
    input logic dir, input logic byp_en, input logic byp_val, input logic a1,
    input logic a2, input logic a2oe, input logic a3, input logic a3oe);
    case (pin_func_e'(sel))
      FUNC_GPIO: pin_expect = byp_en ? {1'b1, byp_val} : {dir, out};
      FUNC_ALT1: pin_expect = {1'b1, a1};
      FUNC_ALT2: pin_expect = {a2oe, a2};
      default:   pin_expect = {a3oe, a3};
    endcase
  endfunction

  assign tb_ready  = (edges_since_rst >= READY_CYCLES);
  assign sam_sel_m = {regs_m[REG_SAM_SEL_HI][SAM_HI_BITS-1:0], regs_m[REG_SAM_SEL_LO]};
  assign wm_sel_m  = {regs_m[REG_WM_SEL_HI][WM_HI_BITS-1:0], regs_m[REG_WM_SEL_LO]};

  always @(posedge wMEM_CLK)
  begin
    if (!rst_n_i)
      edges_since_rst <= 0;
    else if (!tb_ready)
      edges_since_rst <= edges_since_rst + 1;
  end

  // register contents and two-edge pad delay as the host should see them
  always @(posedge wMEM_CLK)
  begin
    if (!tb_ready)
    begin
      for (int i = 0; i < 16; i++)
        regs_m[i] <= '0;
      sam_d1 <= '0;
      sam_d2 <= '0;
      wm_d1  <= '0;
      wm_d2  <= '0;
    end
    else
    begin
      if (reg_we_i)
        regs_m[reg_addr_i] <= reg_wdata_i & reg_mask(reg_addr_i);
      sam_d1 <= sam_pad_i;
      sam_d2 <= sam_d1;
      wm_d1  <= wm_pad_i;
      wm_d2  <= wm_d1;
    end
  end

  always_comb
  begin
    byp_en_m  = '0;
    byp_val_m = '0;
    byp_en_m[BYP_MISO_SAM]  = (wm_sel_m[2*BYP_MISO_WM +: 2] == FUNC_ALT1);
    byp_val_m[BYP_MISO_SAM] = wm_d2[BYP_MISO_WM];
    byp_en_m[BYP_TX_SAM]    = (wm_sel_m[2*BYP_TX_WM +: 2] == FUNC_ALT1);
    byp_val_m[BYP_TX_SAM]   = wm_d2[BYP_TX_WM];
    byp_en_m[BYP_ACK_SAM]   = (wm_sel_m[2*BYP_ACK_WM +: 2] == FUNC_ALT1);
    byp_val_m[BYP_ACK_SAM]  = wm_d2[BYP_ACK_WM];
    wm_alt1_m = '0;
    wm_alt1_m[BYP_RX_WM]    = sam_d2[BYP_RX_SAM];
    wm_alt1_m[BYP_RST_WM]   = sam_d2[BYP_RST_SAM];
    wm_alt1_m[BYP_GPIO0_WM] = sam_d2[BYP_GPIO0_SAM];
    for (int i = 0; i < SAM_PINS; i++)
      {exp_sam_oe[i], exp_sam_pad[i]} = pin_expect(sam_sel_m[2*i +: 2],
        regs_m[REG_SAM_OUT][i], regs_m[REG_SAM_DIR][i], byp_en_m[i], byp_val_m[i],
        sam_alt1_i[i], sam_alt2_i[i], sam_alt2_oe_i[i], sam_alt3_i[i], sam_alt3_oe_i[i]);
    for (int i = 0; i < WM_PINS; i++)   // push-pull ALT, no bypass
      {exp_wm_oe[i], exp_wm_pad[i]} = pin_expect(wm_sel_m[2*i +: 2],
        regs_m[REG_WM_OUT][i], regs_m[REG_WM_DIR][i], 1'b0, 1'b0,
        wm_alt1_m[i], wm_alt2_i[i], 1'b1, wm_alt3_i[i], 1'b1);
  end

  a_ready_time: assert property (@(posedge wMEM_CLK) disable iff (!rst_n_i)
    sys_ready_o == tb_ready) else report_error("sys_ready_o not 32 cycles after reset");
  a_quiet_in_reset: assert property (@(posedge wMEM_CLK) disable iff (!rst_n_i)
    !tb_ready |-> sam_pad_oe_o == '0 && wm_pad_oe_o == '0 && flash_io_oe_o == 4'b0000
    && !reg_rvalid_o) else report_error("output enable or rvalid active in reset");
  a_rvalid_timing: assert property (@(posedge wMEM_CLK) disable iff (!tb_ready)
    reg_rvalid_o == $past(reg_re_i)) else report_error("rvalid not one cycle after read");
  a_read_data: assert property (@(posedge wMEM_CLK) disable iff (!tb_ready)
    reg_rvalid_o |-> reg_rdata_o == $past(exp_rdata)) else report_error("wrong read data");
  a_sam_pads: assert property (@(posedge wMEM_CLK) disable iff (!rst_n_i)
    sam_pad_o == exp_sam_pad && sam_pad_oe_o == exp_sam_oe)
    else report_error("header bank pad value or oe wrong");
  a_wm_pads: assert property (@(posedge wMEM_CLK) disable iff (!rst_n_i)
    wm_pad_o == exp_wm_pad && wm_pad_oe_o == exp_wm_oe)
    else report_error("radio bank pad value or oe wrong");
  a_byp_miso: assert property (@(posedge wMEM_CLK) disable iff (!tb_ready)
    wm_sel_m[2*BYP_MISO_WM +: 2] == FUNC_ALT1 && sam_sel_m[2*BYP_MISO_SAM +: 2] == FUNC_GPIO
    |-> sam_pad_o[BYP_MISO_SAM] == $past(wm_pad_i[BYP_MISO_WM], 2) && sam_pad_oe_o[BYP_MISO_SAM])
    else report_error("header pin 18 does not follow radio pad 20");
  a_byp_rx: assert property (@(posedge wMEM_CLK) disable iff (!tb_ready)
    wm_sel_m[2*BYP_RX_WM +: 2] == FUNC_ALT1
    |-> wm_pad_o[BYP_RX_WM] == $past(sam_pad_i[BYP_RX_SAM], 2) && wm_pad_oe_o[BYP_RX_WM])
    else report_error("radio pin 15 does not follow header pad 22");
  a_flash_cs: assert property (@(posedge wMEM_CLK)
    flash_cs_n_o == (qspi_ncs_i & spi_cs_n_i)) else report_error("flash chip select wrong");
  a_flash_quad: assert property (@(posedge wMEM_CLK) !qspi_ncs_i && !qspi_oe_n_i
    |-> ((flash_io_o ^ qspi_dout_i) & qspi_doe_i) == 4'b0000 && flash_io_oe_o == qspi_doe_i
    && flash_sck_o == qspi_clk_i) else report_error("flash pins wrong under quad traffic");
  a_flash_spi: assert property (@(posedge wMEM_CLK) (qspi_ncs_i || qspi_oe_n_i) && !spi_cs_n_i
    |-> flash_io_o[0] == spi_mosi_i && flash_io_o[3:2] == 2'b11 && flash_io_oe_o == 4'b1101
    && flash_sck_o == spi_sck_i) else report_error("flash pins wrong under SPI traffic");
  a_flash_in: assert property (@(posedge wMEM_CLK)
    qspi_din_o == flash_io_i && spi_miso_o == flash_io_i[1])
    else report_error("flash input data not returned");

  task automatic step();
    @(posedge wMEM_CLK);
    #1;   // inputs change just after the edge
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [REG_W-1:0] data);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    step();
    reg_we_i = 1'b0;
  endtask

  task automatic read_check(input reg_addr_e addr, input logic [REG_W-1:0] expected);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    exp_rdata  = expected;
    step();
    reg_re_i = 1'b0;
    while (!reg_rvalid_o)
      step();
  endtask

  task automatic drive_random_alts();
    sam_alt1_i    = sam_vec_t'($random(seed));
    sam_alt2_i    = sam_vec_t'($random(seed));
    sam_alt2_oe_i = sam_vec_t'($random(seed));
    sam_alt3_i    = sam_vec_t'($random(seed));
    sam_alt3_oe_i = sam_vec_t'($random(seed));
    wm_alt2_i     = wm_vec_t'($random(seed));
    wm_alt3_i     = wm_vec_t'($random(seed));
  endtask

  initial
  begin
    reg_addr_e        addr;
    logic [REG_W-1:0] data;
    rst_n_i     = 1'b0;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = REG_SAM_OUT;
    reg_wdata_i = '0;
    exp_rdata   = '0;
    sam_pad_i   = '0;
    wm_pad_i    = '0;
    sam_alt1_i  = '0;
    sam_alt2_i  = '0;
    sam_alt2_oe_i = '0;
    sam_alt3_i  = '0;
    sam_alt3_oe_i = '0;
    wm_alt2_i   = '0;
    wm_alt3_i   = '0;
    spi_sck_i   = 1'b0;
    spi_cs_n_i  = 1'b1;
    spi_mosi_i  = 1'b0;
    qspi_clk_i  = 1'b0;
    qspi_ncs_i  = 1'b1;
    qspi_oe_n_i = 1'b1;
    qspi_dout_i = 4'h0;
    qspi_doe_i  = 4'h0;
    flash_io_i  = 4'h0;
    repeat (3) @(posedge wMEM_CLK);
    #1;
    rst_n_i = 1'b1;
    write_reg(REG_SAM_DIR, '1);   // still in the stretch, dropped
    reg_re_i   = 1'b1;            // no answer expected yet
    reg_addr_i = REG_SAM_DIR;
    step();
    reg_re_i = 1'b0;
    while (!sys_ready_o)
      step();
    read_check(REG_STATUS, 32'd1);
    read_check(REG_SAM_DIR, '0);
    repeat (48)
    begin
      addr = reg_addr_e'({$random(seed)} % 8);
      data = $random(seed);
      drive_random_alts();
      write_reg(addr, data);
      read_check(addr, data & reg_mask(addr));
    end
    repeat (6)
    begin
      sam_pad_i = sam_vec_t'($random(seed));
      wm_pad_i  = wm_vec_t'($random(seed));
      step();
      step();   // through both synchronizer stages
      read_check(REG_SAM_IN, REG_W'(sam_pad_i));
      read_check(REG_WM_IN, REG_W'(wm_pad_i));
    end
    write_reg(REG_SAM_SEL_LO, '0);
    write_reg(REG_SAM_SEL_HI, '0);   // header 18 and 22 in GPIO
    write_reg(REG_WM_SEL_LO, REG_W'(FUNC_ALT1) << (2*BYP_RX_WM));
    write_reg(REG_WM_SEL_HI, REG_W'(FUNC_ALT1) << (2*(BYP_MISO_WM-SEL_LO_PINS)));
    repeat (24)
    begin
      sam_pad_i = sam_vec_t'($random(seed));
      wm_pad_i  = wm_vec_t'($random(seed));
      drive_random_alts();
      step();
    end
    spi_cs_n_i = 1'b0;
    repeat (16)
    begin
      spi_sck_i  = $random(seed);
      spi_mosi_i = $random(seed);
      flash_io_i = 4'($random(seed));
      step();
    end
    spi_cs_n_i = 1'b1;
    step();
    qspi_ncs_i  = 1'b0;
    qspi_oe_n_i = 1'b0;
    repeat (16)
    begin
      qspi_clk_i  = $random(seed);
      qspi_dout_i = 4'($random(seed));
      qspi_doe_i  = 4'($random(seed));
      flash_io_i  = 4'($random(seed));
      step();
    end
    qspi_oe_n_i = 1'b1;   // selected but not driving
    repeat (4) step();
    qspi_ncs_i = 1'b1;
    repeat (4) step();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
verilog/periph_pkg.sv
verilog/pinmux_pkg.sv
verilog/pio_bank_if.sv
verilog/reset_stretch.sv
verilog/pio_regs.sv
verilog/pad_sync_route.sv
verilog/pin_mux.sv
verilog/flash_pin_share.sv
verilog/periph_top.sv
bench/tb_periph.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_periph -Mdir obj_dir -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_periph
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished without errors"
exit 0
